//--- design/game_pkg.sv
package game_pkg;

    // Playfield size in tiles
    localparam int grid_cols   = 32;
    localparam int grid_rows   = 24;
    localparam int pillar_step = 4; // Interior pillars sit on multiples of this

    localparam int tile_x_w = 5;
    localparam int tile_y_w = 5;
    localparam int score_w  = 8;

    // Start tiles, the rival one is kept free but never occupied
    localparam logic [tile_x_w-1:0] start_x = 5'd1;
    localparam logic [tile_y_w-1:0] start_y = 5'd1;
    localparam logic [tile_x_w-1:0] rival_x = 5'd30;
    localparam logic [tile_y_w-1:0] rival_y = 5'd22;

    // First point after reset
    localparam logic [tile_x_w-1:0] point_init_x = 5'd16;
    localparam logic [tile_y_w-1:0] point_init_y = 5'd2;

    // LFSR seeds, any non-zero value works
    localparam logic [4:0] lfsr_x_seed = 5'd1;
    localparam logic [4:0] lfsr_y_seed = 5'd7;

    // Register byte offsets
    localparam logic [3:0] addr_cmd    = 4'h0;
    localparam logic [3:0] addr_player = 4'h4;
    localparam logic [3:0] addr_point  = 4'h8;
    localparam logic [3:0] addr_score  = 4'hC;

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;

    typedef enum logic [2:0] {
        cmd_nop   = 3'd0,
        cmd_up    = 3'd1, // Row decreases
        cmd_down  = 3'd2,
        cmd_left  = 3'd3,
        cmd_right = 3'd4
    } game_cmd_e;

    typedef enum logic {
        spawn_hold   = 1'b0,
        spawn_search = 1'b1
    } spawn_state_e;

endpackage

//--- design/axil_cmd_write.sv
`timescale 1ns/1ps

module axil_cmd_write import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    output game_cmd_e   cmd,
    output logic        cmd_valid
);

    game_cmd_e decoded;
    logic      addr_hit;

    assign addr_hit = (awaddr == addr_cmd);

    // Codes above cmd_right fall back to a no-op
    always_comb begin
        case (wdata[2:0])
            3'd1:    decoded = cmd_up;
            3'd2:    decoded = cmd_down;
            3'd3:    decoded = cmd_left;
            3'd4:    decoded = cmd_right;
            default: decoded = cmd_nop;
        endcase
    end

    assign wready = awready; // Address and data are always taken together

    always_ff @(posedge clk) begin
        if (rst) begin
            awready   <= 1'b0;
            bvalid    <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (awready) begin
                awready   <= 1'b0; // Single-cycle ready, the transfer happens here
                bvalid    <= 1'b1;
                cmd_valid <= addr_hit && (decoded != cmd_nop);
            end else if (!bvalid && awvalid && wvalid) begin
                awready <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awready) begin
            bresp <= addr_hit ? resp_okay : resp_slverr;
            cmd   <= decoded;
        end
    end

endmodule

//--- design/terrain_map.sv
`timescale 1ns/1ps

module terrain_map import game_pkg::*; (
    input  logic [tile_x_w-1:0] ax,
    input  logic [tile_y_w-1:0] ay,
    input  logic [tile_x_w-1:0] bx,
    input  logic [tile_y_w-1:0] by,
    output logic                wall_a,
    output logic                wall_b
);

    // Border ring, pillar grid, and anything past the playfield edge
    function automatic logic is_wall(input logic [tile_x_w-1:0] x,
                                     input logic [tile_y_w-1:0] y);
        int  xi;
        int  yi;
        logic outside;
        logic border;
        logic pillar;
        xi      = int'(x);
        yi      = int'(y);
        outside = (xi >= grid_cols) || (yi >= grid_rows);
        border  = (xi == 0) || (yi == 0) || (xi == grid_cols - 1) || (yi == grid_rows - 1);
        pillar  = ((xi % pillar_step) == 0) && ((yi % pillar_step) == 0);
        return outside || border || pillar;
    endfunction

    assign wall_a = is_wall(ax, ay); // Player target
    assign wall_b = is_wall(bx, by); // Spawn candidate

endmodule

//--- design/player_mover.sv
`timescale 1ns/1ps

module player_mover import game_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  game_cmd_e           cmd,
    input  logic                cmd_valid,
    input  logic                wall_a,
    output logic [tile_x_w-1:0] player_x,
    output logic [tile_y_w-1:0] player_y,
    output logic [tile_x_w-1:0] target_x,
    output logic [tile_y_w-1:0] target_y
);

    // Neighbour tile for the pending command
    always_comb begin
        target_x = player_x;
        target_y = player_y;
        case (cmd)
            cmd_up: begin
                if (player_y != '0) begin
                    target_y = player_y - 1'b1;
                end
            end
            cmd_down: begin
                target_y = player_y + 1'b1; // Past the last row counts as a wall
            end
            cmd_left: begin
                if (player_x != '0) begin
                    target_x = player_x - 1'b1;
                end
            end
            cmd_right: begin
                target_x = player_x + 1'b1;
            end
            default: begin
                target_x = player_x;
                target_y = player_y;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            player_x <= start_x;
            player_y <= start_y;
        end else if (cmd_valid && !wall_a) begin
            player_x <= target_x; // Blocked moves are simply dropped
            player_y <= target_y;
        end
    end

endmodule

//--- design/point_spawner.sv
`timescale 1ns/1ps

module point_spawner import game_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [tile_x_w-1:0] player_x,
    input  logic [tile_y_w-1:0] player_y,
    input  logic                wall_b,
    output logic [tile_x_w-1:0] cand_x,
    output logic [tile_y_w-1:0] cand_y,
    output logic [tile_x_w-1:0] point_x,
    output logic [tile_y_w-1:0] point_y,
    output logic                point_valid,
    output logic [score_w-1:0]  score
);

    logic [4:0]   lfsr_x;
    logic [4:0]   lfsr_y;
    logic [4:0]   lfsr_y_next;
    logic         hit;
    logic         cand_ok;
    spawn_state_e state;

    // x^5 + x^3 + 1, period 31
    function automatic logic [4:0] lfsr_step(input logic [4:0] v);
        return {v[3:0], v[4] ^ v[2]};
    endfunction

    // Both LFSRs share a period, so y takes one extra step per x period.
    // That slides the phase and the pair walks through all 961 combinations.
    always_comb begin
        lfsr_y_next = lfsr_step(lfsr_y);
        if (lfsr_x == lfsr_x_seed) begin
            lfsr_y_next = lfsr_step(lfsr_y_next);
        end
    end

    assign cand_x = lfsr_x - 5'd1; // 1..31 maps to columns 0..30
    assign cand_y = (lfsr_y >= grid_rows) ? lfsr_y - 5'(grid_rows) : lfsr_y;

    assign cand_ok = !wall_b
                  && !(cand_x == start_x && cand_y == start_y)
                  && !(cand_x == rival_x && cand_y == rival_y)
                  && !(cand_x == player_x && cand_y == player_y);

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_x      <= lfsr_x_seed;
            lfsr_y      <= lfsr_y_seed;
            hit         <= 1'b0;
            state       <= spawn_hold;
            point_x     <= point_init_x;
            point_y     <= point_init_y;
            point_valid <= 1'b1;
            score       <= '0;
        end else begin
            lfsr_x <= lfsr_step(lfsr_x);
            lfsr_y <= lfsr_y_next;
            hit    <= point_valid && (player_x == point_x) && (player_y == point_y);
            case (state)
                spawn_hold: begin
                    if (hit) begin
                        score       <= score + 1'b1; // Wraps at 255
                        point_valid <= 1'b0;
                        state       <= spawn_search;
                    end
                end
                spawn_search: begin
                    if (cand_ok) begin
                        point_x     <= cand_x;
                        point_y     <= cand_y;
                        point_valid <= 1'b1;
                        state       <= spawn_hold;
                    end
                end
                default: state <= spawn_hold;
            endcase
        end
    end

endmodule

//--- design/axil_status_read.sv
`timescale 1ns/1ps

module axil_status_read import game_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [3:0]          araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic [tile_x_w-1:0] player_x,
    input  logic [tile_y_w-1:0] player_y,
    input  logic [tile_x_w-1:0] point_x,
    input  logic [tile_y_w-1:0] point_y,
    input  logic                point_valid,
    input  logic [score_w-1:0]  score
);

    logic [31:0] rd_word;
    logic [1:0]  rd_resp;

    always_comb begin
        rd_word = '0;
        rd_resp = resp_okay;
        case (araddr)
            addr_player: begin
                rd_word[4:0]  = player_x;
                rd_word[12:8] = player_y;
            end
            addr_point: begin
                rd_word[4:0]  = point_x;
                rd_word[12:8] = point_y;
                rd_word[16]   = point_valid;
            end
            addr_score: rd_word[7:0] = score;
            addr_cmd:   rd_word = '0; // Command register reads back as zero
            default:    rd_resp = resp_slverr;
        endcase
    end

    assign arready = !rvalid; // One read in flight at a time

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Data is frozen at the address transfer and held until accepted
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

//--- design/maze_game_top.sv
`timescale 1ns/1ps

module maze_game_top import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    game_cmd_e             cmd;
    logic                  cmd_valid;
    logic [tile_x_w-1:0]   player_x;
    logic [tile_y_w-1:0]   player_y;
    logic [tile_x_w-1:0]   target_x;
    logic [tile_y_w-1:0]   target_y;
    logic [tile_x_w-1:0]   cand_x;
    logic [tile_y_w-1:0]   cand_y;
    logic [tile_x_w-1:0]   point_x;
    logic [tile_y_w-1:0]   point_y;
    logic                  point_valid;
    logic [score_w-1:0]    score;
    logic                  wall_a;
    logic                  wall_b;

    axil_cmd_write u_axil_cmd_write (
        .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready, .cmd, .cmd_valid
    );

    player_mover u_player_mover (
        .clk, .rst, .cmd, .cmd_valid, .wall_a,
        .player_x, .player_y, .target_x, .target_y
    );

    // Port A serves the mover, port B the spawner
    terrain_map u_terrain_map (
        .ax(target_x), .ay(target_y), .bx(cand_x), .by(cand_y),
        .wall_a, .wall_b
    );

    point_spawner u_point_spawner (
        .clk, .rst, .player_x, .player_y, .wall_b, .cand_x, .cand_y,
        .point_x, .point_y, .point_valid, .score
    );

    axil_status_read u_axil_status_read (
        .clk, .rst, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .player_x, .player_y, .point_x, .point_y, .point_valid, .score
    );

endmodule

//--- tb/maze_game_checker.sv
`timescale 1ns/1ps

module maze_game_checker (
    input logic        clk,
    input logic        rst,
    input logic        awready,
    input logic        wready,
    input logic [1:0]  bresp,
    input logic        bvalid,
    input logic        bready,
    input logic        arready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        rvalid,
    input logic        rready
);

    logic failed = 1'b0; // Goes high once any assertion below has failed

    // A stalled write response keeps its code until it is taken
    bresp_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            failed = 1'b1;
            $error("Write response dropped or changed before the handshake");
        end

    rdata_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            failed = 1'b1;
            $error("Read data dropped or changed before the handshake");
        end

    no_accept_pending: assert property (@(posedge clk) disable iff (rst)
        awready |-> !bvalid)
        else begin
            failed = 1'b1;
            $error("Write accepted while a response is still pending");
        end

    // Address and data are taken together, for one cycle only
    ready_pair: assert property (@(posedge clk) disable iff (rst)
        awready == wready)
        else begin
            failed = 1'b1;
            $error("awready and wready differ");
        end

    ready_pulse: assert property (@(posedge clk) disable iff (rst)
        awready |=> !awready)
        else begin
            failed = 1'b1;
            $error("awready held for more than one cycle");
        end

    ar_one_read: assert property (@(posedge clk) disable iff (rst)
        arready == !rvalid)
        else begin
            failed = 1'b1;
            $error("arready high while a read is in flight");
        end

endmodule

bind maze_game_top maze_game_checker u_maze_game_checker (
    .clk, .rst, .awready, .wready, .bresp, .bvalid, .bready,
    .arready, .rdata, .rresp, .rvalid, .rready
);

//--- tb/maze_game_tb.sv
`timescale 1ns/1ps

module maze_game_tb import game_pkg::*; ();

    logic        clk;
    logic        rst;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int cycles = 0;
    int exp_x; // Model of the player tile
    int exp_y;

    maze_game_top u_maze_game_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // About 10 pickups of up to 60 moves at 20 cycles each
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 20000) begin
            $display("TB FAILED");
            $fatal(1, "Timeout, the run went past 20000 cycles");
        end else if (u_maze_game_top.u_maze_game_checker.failed) begin
            $display("TB FAILED");
            $fatal(1, "A bus protocol assertion failed");
        end
    end

    task automatic stop_on_error();
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s exp %0h got %0h", name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            stop_on_error();
        end
    endtask

    // Border ring of the 32 by 24 grid, plus pillars where both coordinates are multiples of 4
    function automatic logic is_wall_tile(input int x, input int y);
        return x <= 0 || y <= 0 || x >= 31 || y >= 23 || (x % 4 == 0 && y % 4 == 0);
    endfunction

    function automatic logic [31:0] tile_word(input int x, input int y);
        return (32'(y) << 8) | 32'(x);
    endfunction

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!awready) @(negedge clk);
        @(negedge clk); // Address and data were taken on the edge just passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat ($urandom % 4) @(negedge clk); // Stall the response for a while
        bready = 1'b1;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    // A second command is offered while the first response is held back
    task automatic write_during_stall();
        logic [1:0] resp;
        @(negedge clk);
        awaddr  = addr_cmd;
        wdata   = 32'd0;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!awready) @(negedge clk);
        repeat (6) @(negedge clk); // The second write waits behind the pending response
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
        expect_eq("bresp", 32'(resp), 32'(resp_okay));
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        repeat ($urandom % 4) @(negedge clk);
        rready = 1'b1;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic check_player();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr_player, data, resp);
        expect_eq("rresp", 32'(resp), 32'(resp_okay));
        expect_eq("player_x", 32'(data[4:0]), 32'(exp_x));
        expect_eq("player_y", 32'(data[12:8]), 32'(exp_y));
        expect_eq("rdata", data, tile_word(exp_x, exp_y)); // No stray bits
    endtask

    task automatic move_player(input int code);
        int         tx;
        int         ty;
        logic [1:0] resp;
        tx = exp_x;
        ty = exp_y;
        case (code)
            1: ty = exp_y - 1; // Up lowers the row
            2: ty = exp_y + 1;
            3: tx = exp_x - 1;
            4: tx = exp_x + 1;
            default: ;
        endcase
        if (!is_wall_tile(tx, ty)) begin
            exp_x = tx;
            exp_y = ty;
        end
        axi_write(addr_cmd, 32'(code), resp);
        expect_eq("bresp", 32'(resp), 32'(resp_okay));
        check_player();
    endtask

    task automatic walk_to(input int tx, input int ty);
        int cx;
        cx = tx;
        if (tx % 4 == 0) begin
            cx = (exp_x < tx) ? tx - 1 : tx + 1; // Pillar column, use its neighbour
        end
        if (exp_y % 4 == 0) move_player(2);
        while (exp_x < cx) move_player(4);
        while (exp_x > cx) move_player(3);
        while (exp_y < ty) move_player(2);
        while (exp_y > ty) move_player(1);
        while (exp_x < tx) move_player(4);
        while (exp_x > tx) move_player(3);
    endtask

    task automatic collect_point();
        logic [31:0] data;
        logic [31:0] score_before;
        logic [1:0]  resp;
        int          px;
        int          py;
        axi_read(addr_score, score_before, resp);
        axi_read(addr_point, data, resp);
        walk_to(int'(data[4:0]), int'(data[12:8]));
        do begin
            axi_read(addr_point, data, resp);
        end while (!data[16]);
        expect_eq("rresp", 32'(resp), 32'(resp_okay));
        px = int'(data[4:0]);
        py = int'(data[12:8]);
        expect_true(!is_wall_tile(px, py), "New point was spawned on a wall");
        expect_true(!(px == 1 && py == 1), "New point was spawned on the player start tile");
        expect_true(!(px == 30 && py == 22), "New point was spawned on the rival start tile");
        expect_true(!(px == exp_x && py == exp_y), "New point was spawned on the player tile");
        axi_read(addr_score, data, resp);
        expect_eq("score", data, (score_before + 32'd1) & 32'hff);
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        void'($urandom(3));
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        exp_x   = 1;
        exp_y   = 1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        axi_read(addr_player, data, resp);
        expect_eq("player", data, tile_word(1, 1));
        axi_read(addr_point, data, resp);
        expect_eq("point", data, tile_word(16, 2) | 32'h1_0000);
        axi_read(addr_score, data, resp);
        expect_eq("score", data, 32'h0);
        expect_eq("rresp", 32'(resp), 32'(resp_okay));

        move_player(1); // Border above
        move_player(3); // Border to the left
        move_player(0);
        move_player(7); // Unknown code
        repeat (3) move_player(2);
        repeat (2) move_player(4);
        move_player(4); // Pillar at (4,4)
        move_player(2);
        move_player(4);
        move_player(1); // Same pillar from below

        axi_write(addr_player, 32'd4, resp); // A move sent to the wrong register
        expect_eq("bresp", 32'(resp), 32'(resp_slverr));
        check_player();
        axi_read(4'h6, data, resp);
        expect_eq("rresp", 32'(resp), 32'(resp_slverr));
        expect_eq("rdata", data, 32'h0);

        write_during_stall();
        check_player();

        repeat (8) collect_point();

        if (u_maze_game_top.u_maze_game_checker.failed) begin
            $display("TB FAILED");
            $fatal(1, "A bus protocol assertion failed");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- project.f
design/game_pkg.sv
design/axil_cmd_write.sv
design/terrain_map.sv
design/player_mover.sv
design/point_spawner.sv
design/axil_status_read.sv
design/maze_game_top.sv
tb/maze_game_checker.sv
tb/maze_game_tb.sv

//--- Makefile
all: run

obj_dir/Vmaze_game_tb: project.f $(wildcard design/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module maze_game_tb -o Vmaze_game_tb

run: obj_dir/Vmaze_game_tb
	./obj_dir/Vmaze_game_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TB FAILED" sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
